// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = execTb
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: src.f
+incdir+src
src/mipsPkg.sv
src/controlUnit.sv
src/registerFile.sv
src/alu.sv
src/execRegs.sv
src/execTop.sv
verif/exec_properties.sv
verif/execTb.sv

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0]       readData1,
    input  logic [31:0]       readData2,
    input  logic [31:0]       immExt,
    input  logic [31:0]       pcPlus4,
    input  mipsPkg::instrWord instr,
    input  mipsPkg::aluCtrl   ctrl,
    output logic [31:0]       aluResult,
    output logic [31:0]       addrResult,
    output logic              zero
);

    logic [31:0] aInput;
    logic [31:0] bInput;
    logic [31:0] diff;
    logic [31:0] opResult;
    logic [31:0] shiftResult;
    logic [5:0]  exeCode;
    logic [2:0]  aluCtl;
    logic [4:0]  shiftAmt;
    logic        isSet;
    logic        setResult;

    assign aInput = readData1;
    assign bInput = ctrl.aluSrc ? immExt : readData2;
    assign diff   = aInput - bInput;

    // funct for R-type, low opcode bits for I-type
    assign exeCode = ctrl.iFormat ? {3'b000, instr.iFields.opcode[2:0]}
                                  : instr.rFields.funct;

    assign aluCtl[0] = (exeCode[0] | exeCode[3]) & ctrl.aluOp[1];
    assign aluCtl[1] = ~exeCode[2] | ~ctrl.aluOp[1];
    assign aluCtl[2] = (exeCode[1] & ctrl.aluOp[1]) | ctrl.aluOp[0];

    // 11x codes are subtract unless slt, sltu, slti or sltiu
    assign isSet     = ctrl.aluOp[1] & (ctrl.iFormat | exeCode[3]);
    assign setResult = exeCode[0] ? (aInput < bInput)
                                  : ($signed(aInput) < $signed(bInput));

    always_comb begin
        case (aluCtl)
            3'b000: opResult = aInput & bInput;
            3'b001: opResult = aInput | bInput;
            3'b010, 3'b011: opResult = aInput + bInput;  // add, addu, addi, addiu
            3'b100: opResult = aInput ^ bInput;
            3'b101: opResult = ctrl.iFormat ? {bInput[15:0], 16'h0000}    // lui
                                            : ~(aInput | bInput);         // nor
            default: begin
                if (isSet) begin
                    opResult = {31'd0, setResult};
                end else begin
                    opResult = diff;  // sub, subu, branch compare
                end
            end
        endcase
    end

    // variable forms take the amount from rs
    assign shiftAmt = instr.rFields.funct[2] ? readData1[4:0] : instr.rFields.shamt;

    always_comb begin
        case (instr.rFields.funct[1:0])
            2'b00:   shiftResult = bInput << shiftAmt;
            2'b10:   shiftResult = bInput >> shiftAmt;
            2'b11:   shiftResult = $signed(bInput) >>> shiftAmt;  // keeps the sign
            default: shiftResult = bInput;
        endcase
    end

    assign aluResult = ctrl.sftmd ? shiftResult : opResult;

    assign zero = ctrl.branch ? (diff == 32'd0) : (aluResult == 32'd0);

    // branch target is word offset from pc+4, jr goes to rs
    assign addrResult = ctrl.jr ? readData1 : pcPlus4 + {immExt[29:0], 2'b00};

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  mipsPkg::instrWord instr,
    output mipsPkg::aluCtrl   ctrl,
    output logic [31:0]       immExt
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic        rFormat;
    logic        iFormat;
    logic        isBranch;
    logic        isJr;
    logic        rLegal;
    logic        zeroExt;

    assign opcode = instr.iFields.opcode;
    assign funct  = instr.rFields.funct;
    assign imm    = instr.iFields.imm;

    assign rFormat  = (opcode == 6'b000000);
    assign iFormat  = (opcode[5:3] == 3'b001);     // addi .. lui
    assign isBranch = (opcode[5:1] == 5'b00010);   // beq, bne
    assign isJr     = rFormat & (funct == 6'b001000);

    // supported R-type function codes
    assign rLegal = funct inside {
        6'b000000,              // sll
        6'b000010,              // srl
        6'b000011,              // sra
        6'b000100,              // sllv
        6'b000110,              // srlv
        6'b000111,              // srav
        6'b001000,              // jr
        [6'b100000:6'b100111],  // add .. nor
        6'b101010,              // slt
        6'b101011               // sltu
    };

    always_comb begin
        ctrl.aluOp    = {rFormat | iFormat, isBranch};
        ctrl.aluSrc   = iFormat;
        ctrl.iFormat  = iFormat;
        ctrl.sftmd    = rFormat & (funct[5:3] == 3'b000);
        ctrl.jr       = isJr;
        ctrl.branch   = isBranch;
        ctrl.regWrite = (rFormat & ~isJr) | iFormat;
        ctrl.regDst   = rFormat;
        ctrl.illegal  = ~((rFormat & rLegal) | iFormat | isBranch);
    end

    // andi, ori, xori take the immediate unsigned; lui ignores the upper half
    assign zeroExt = (opcode[5:2] == 4'b0011);

    assign immExt = zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};

endmodule

// File: src/execRegs.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module execRegs (
    input  logic              clock,
    input  logic              rst,
    input  mipsPkg::apbReq    apbIn,
    output mipsPkg::apbRsp    apbOut,
    output mipsPkg::instrWord instr,
    output logic [31:0]       pcPlus4,
    input  mipsPkg::aluCtrl   ctrl,
    input  logic [31:0]       aluResult,
    input  logic [31:0]       addrResult,
    input  logic              zero,
    output logic [4:0]        rfRdAddr,
    input  logic [31:0]       rfRdData,
    output mipsPkg::rfWrite   rfWr
);

    import mipsPkg::*;

    logic [11:0] winOffset;
    logic        access;
    logic        ready;
    logic        done;
    logic        instrWr;
    logic        execPhase;   // second access cycle of an instruction write
    logic        execDone;
    logic        inWindow;
    logic        isInstr;
    logic        isPc;
    logic        isResult;
    logic        isAddr;
    logic        isStatus;
    logic        readOnly;
    logic        addrErr;
    logic        branchTaken;
    logic [31:0] resultReg;
    logic [31:0] addrReg;
    logic [3:0]  statusReg;
    rfWrite      winWr;
    rfWrite      wbWr;

    assign access    = apbIn.psel & apbIn.penable;
    assign winOffset = apbIn.paddr - `EXEC_REG_BASE;
    assign inWindow  = (winOffset < 12'(`MIPS_NREGS * 4)) & (winOffset[1:0] == 2'b00);
    assign isInstr   = (apbIn.paddr == `EXEC_INSTR);
    assign isPc      = (apbIn.paddr == `EXEC_PC);
    assign isResult  = (apbIn.paddr == `EXEC_RESULT);
    assign isAddr    = (apbIn.paddr == `EXEC_ADDR);
    assign isStatus  = (apbIn.paddr == `EXEC_STATUS);
    assign readOnly  = isResult | isAddr | isStatus;
    assign addrErr   = ~(inWindow | isInstr | isPc | readOnly) | (apbIn.pwrite & readOnly);

    // one wait state for instruction writes, zero for everything else
    assign instrWr  = access & apbIn.pwrite & isInstr;
    assign ready    = ~(instrWr & ~execPhase);
    assign done     = access & ready;
    assign execDone = instrWr & execPhase;

    assign branchTaken = ctrl.branch & ~ctrl.illegal & (instr.iFields.opcode[0] ^ zero);

    always_comb begin
        apbOut.pready  = ready;
        apbOut.pslverr = done & (addrErr | (execDone & ctrl.illegal));
        if (inWindow) begin
            apbOut.prdata = rfRdData;
        end else if (isInstr) begin
            apbOut.prdata = instr;
        end else if (isPc) begin
            apbOut.prdata = pcPlus4;
        end else if (isResult) begin
            apbOut.prdata = resultReg;
        end else if (isAddr) begin
            apbOut.prdata = addrReg;
        end else if (isStatus) begin
            apbOut.prdata = {28'd0, statusReg};
        end else begin
            apbOut.prdata = '0;
        end
    end

    assign rfRdAddr = winOffset[6:2];

    // window writes and writeback never coincide
    always_comb begin
        winWr.en   = done & apbIn.pwrite & inWindow;
        winWr.addr = winOffset[6:2];
        winWr.data = apbIn.pwdata;
        wbWr.en    = execDone & ctrl.regWrite & ~ctrl.illegal & ~ctrl.branch & ~ctrl.jr;
        wbWr.addr  = ctrl.regDst ? instr.rFields.rd : instr.rFields.rt;
        wbWr.data  = aluResult;
    end

    assign rfWr = wbWr.en ? wbWr : winWr;

    always_ff @(posedge clock) begin
        if (rst) begin
            execPhase <= 1'b0;
            instr     <= '0;
            pcPlus4   <= '0;
            statusReg <= '0;
        end else begin
            execPhase <= instrWr & ~execPhase;
            if (instrWr & ~execPhase) begin
                instr <= apbIn.pwdata;  // latched in the wait cycle
            end
            if (done & apbIn.pwrite & isPc) begin
                pcPlus4 <= apbIn.pwdata;
            end
            if (execDone) begin
                statusReg <= {branchTaken, ctrl.illegal,
                              ctrl.jr & ~ctrl.illegal, zero & ~ctrl.illegal};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (execDone & ~ctrl.illegal) begin
            resultReg <= aluResult;
            addrReg   <= addrResult;
        end
    end

endmodule

// File: src/execTop.sv
`timescale 1ns/1ps

module execTop (
    input  logic           clock,
    input  logic           rst,
    input  mipsPkg::apbReq apbIn,
    output mipsPkg::apbRsp apbOut
);

    import mipsPkg::*;

    instrWord    instr;
    aluCtrl      ctrl;
    rfWrite      rfWr;
    logic [31:0] pcPlus4;
    logic [31:0] immExt;
    logic [31:0] aluResult;
    logic [31:0] addrResult;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] rfRdData;
    logic [4:0]  rfRdAddr;
    logic        zero;

    execRegs u_execRegs (
        .clock(clock), .rst(rst), .apbIn(apbIn), .apbOut(apbOut),
        .instr(instr), .pcPlus4(pcPlus4), .ctrl(ctrl),
        .aluResult(aluResult), .addrResult(addrResult), .zero(zero),
        .rfRdAddr(rfRdAddr), .rfRdData(rfRdData), .rfWr(rfWr)
    );

    controlUnit u_controlUnit (.instr(instr), .ctrl(ctrl), .immExt(immExt));

    registerFile u_registerFile (
        .clock(clock), .rst(rst),
        .rs(instr.rFields.rs), .rt(instr.rFields.rt), .winAddr(rfRdAddr),
        .rsData(rsData), .rtData(rtData), .winData(rfRdData), .wr(rfWr)
    );

    alu u_alu (
        .readData1(rsData), .readData2(rtData), .immExt(immExt), .pcPlus4(pcPlus4),
        .instr(instr), .ctrl(ctrl),
        .aluResult(aluResult), .addrResult(addrResult), .zero(zero)
    );

endmodule

// File: src/mipsPkg.sv
package mipsPkg;

`include "mips_config.svh"

    // R-type view of an instruction word
    typedef struct packed {
        logic [`MIPS_OP_W-1:0]   opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [`MIPS_OP_W-1:0]   funct;
    } rType;

    // I-type view of the same word
    typedef struct packed {
        logic [`MIPS_OP_W-1:0]   opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_IMM_W-1:0]  imm;
    } iType;

    typedef union packed {
        rType rFields;
        iType iFields;
    } instrWord;

    typedef struct packed {
        logic [1:0] aluOp;      // {R or I arith, beq/bne}
        logic       aluSrc;     // operand b from immediate
        logic       iFormat;    // I-type arith/logic
        logic       sftmd;      // shift instruction
        logic       jr;
        logic       branch;
        logic       regWrite;
        logic       regDst;     // rd when set, else rt
        logic       illegal;
    } aluCtrl;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`APB_ADDR_W-1:0]  paddr;
        logic [`MIPS_DATA_W-1:0] pwdata;
    } apbReq;

    typedef struct packed {
        logic [`MIPS_DATA_W-1:0] prdata;
        logic                    pready;
        logic                    pslverr;
    } apbRsp;

    typedef struct packed {
        logic                    en;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_DATA_W-1:0] data;
    } rfWrite;

endpackage

// File: src/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// APB register map
`define EXEC_REG_BASE 12'h000   // 32-word register window
`define EXEC_INSTR    12'h080   // instruction word, rw
`define EXEC_PC       12'h084   // pc+4, rw
`define EXEC_RESULT   12'h088   // alu result, ro
`define EXEC_ADDR     12'h08C   // branch or jr target, ro
`define EXEC_STATUS   12'h090   // {branchTaken, illegal, jr, zero}, ro

`define MIPS_NREGS    32

// field widths
`define APB_ADDR_W    12
`define MIPS_DATA_W   32
`define MIPS_REG_AW   5
`define MIPS_OP_W     6
`define MIPS_IMM_W    16

`endif

// File: src/registerFile.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module registerFile (
    input  logic           clock,
    input  logic           rst,
    input  logic [4:0]     rs,
    input  logic [4:0]     rt,
    input  logic [4:0]     winAddr,
    output logic [31:0]    rsData,
    output logic [31:0]    rtData,
    output logic [31:0]    winData,
    input  mipsPkg::rfWrite wr
);

    logic [31:0] regs [`MIPS_NREGS];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != 5'd0)) begin  // r0 never written
            regs[wr.addr] <= wr.data;
        end
    end

    // combinational reads, two for execute and one for the apb window
    assign rsData  = (rs == 5'd0) ? '0 : regs[rs];
    assign rtData  = (rt == 5'd0) ? '0 : regs[rt];
    assign winData = (winAddr == 5'd0) ? '0 : regs[winAddr];

endmodule

// File: verif/execTb.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module execTb;

    import mipsPkg::*;

    localparam int numInstr    = 300;
    localparam int cycleLimit  = numInstr * 30 + 3000;  // ~28 cycles per instruction plus sweeps
    localparam int kindAlu     = 0;
    localparam int kindBranch  = 1;
    localparam int kindJr      = 2;
    localparam int kindIllegal = 3;

    // {R-type, funct} or {0, opcode}
    localparam logic [6:0] legalCodes [27] = '{
        7'h60, 7'h61, 7'h62, 7'h63, 7'h64, 7'h65, 7'h66, 7'h67, 7'h6A, 7'h6B,
        7'h40, 7'h42, 7'h43, 7'h44, 7'h46, 7'h47, 7'h48,
        7'h08, 7'h09, 7'h0A, 7'h0B, 7'h0C, 7'h0D, 7'h0E, 7'h0F, 7'h04, 7'h05
    };
    localparam logic [6:0] illegalCodes [8] = '{  // lw sw j jal blez bgtz jalr mult
        7'h23, 7'h2B, 7'h02, 7'h03, 7'h06, 7'h07, 7'h49, 7'h58
    };

    logic        clock = 1'b0;
    logic        rst;
    apbReq       apbIn;
    apbRsp       apbOut;
    logic [31:0] lcgState;
    logic [31:0] shadow [`MIPS_NREGS];  // model copy of the register file
    logic [31:0] resultExp;
    logic [31:0] addrExp;
    logic        resultKnown;             // RESULT holds a value the ISA defines
    logic        addrKnown;
    int          errorCount;
    int          checkCount;
    int          cycleCount;

    execTop u_execTop (.clock(clock), .rst(rst), .apbIn(apbIn), .apbOut(apbOut));

    always #50 clock = ~clock;

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("errors: %0d of %0d checks", errorCount, checkCount);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randBelow(input int n);
        return int'((nextRandom() >> 8) % n);  // low lcg bits repeat too soon
    endfunction

    function automatic logic [11:0] regAddr(input logic [4:0] n);
        return `EXEC_REG_BASE + {5'd0, n, 2'b00};
    endfunction

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkWaits(input logic [11:0] addr, input int expected, input int actual);
        checkCount++;
        assert (actual == expected) else begin
            errorCount++;
            $display("access to %h took %0d wait states instead of %0d", addr, actual, expected);
        end
    endtask

    // one APB transfer with an idle cycle in front
    task automatic apbTransfer(input logic write, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err, output int waits);
        apbReq req;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        waits = 0;
        @(posedge clock);
        apbIn <= req;                 // setup
        @(posedge clock);
        apbIn.penable <= 1'b1;        // access
        @(negedge clock);
        while (!apbOut.pready) begin
            waits++;
            @(negedge clock);
        end
        rdata = apbOut.prdata;
        err   = apbOut.pslverr;
        @(posedge clock);             // completing edge
        apbIn <= '0;
    endtask

    task automatic busOp(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                         input logic expErr, output logic [31:0] rdata);
        logic err;
        int   waits;
        apbTransfer(write, addr, wdata, rdata, err, waits);
        checkEq("pslverr", {31'd0, expErr}, {31'd0, err});
        checkWaits(addr, 0, waits);
    endtask

    task automatic writeReg(input logic [4:0] n, input logic [31:0] value);
        logic [31:0] rdata;
        busOp(1'b1, regAddr(n), value, 1'b0, rdata);
        if (n != 5'd0) shadow[n] = value;
    endtask

    task automatic readReg(input logic [4:0] n);
        logic [31:0] rdata;
        busOp(1'b0, regAddr(n), '0, 1'b0, rdata);
        checkEq($sformatf("r%0d", n), shadow[n], rdata);
    endtask

    task automatic sweepRegs();
        for (int n = 0; n < `MIPS_NREGS; n++) begin
            readReg(5'(n));
        end
    endtask

    // RESULT and ADDR as far as the model knows them
    task automatic checkOutputRegs();
        logic [31:0] rdata;
        if (resultKnown) begin
            busOp(1'b0, `EXEC_RESULT, '0, 1'b0, rdata);
            checkEq("RESULT", resultExp, rdata);
        end
        if (addrKnown) begin
            busOp(1'b0, `EXEC_ADDR, '0, 1'b0, rdata);
            checkEq("ADDR", addrExp, rdata);
        end
    endtask

    function automatic instrWord randomInstr();
        instrWord   iw;
        logic [6:0] code;
        iw = nextRandom();  // random registers, shamt and immediate
        if (randBelow(100) < 5) begin
            code = illegalCodes[3'(randBelow(8))];
        end else begin
            code = legalCodes[5'(randBelow(27))];
        end
        if (code[6]) begin
            iw.rFields.opcode = 6'b000000;
            iw.rFields.funct  = code[5:0];
        end else begin
            iw.iFields.opcode = code[5:0];
        end
        return iw;
    endfunction

    // ISA behavior of one instruction on the shadow registers
    task automatic modelExec(input instrWord iw, input logic [31:0] pc,
                             output logic [31:0] result, output logic [31:0] target,
                             output logic [3:0] status, output logic wbEn,
                             output logic [4:0] wbReg, output int kind);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] seImm;
        logic [31:0] zeImm;
        logic        taken;
        a      = shadow[iw.rFields.rs];
        b      = shadow[iw.rFields.rt];
        seImm  = {{16{iw.iFields.imm[15]}}, iw.iFields.imm};
        zeImm  = {16'h0000, iw.iFields.imm};
        result = '0;
        target = '0;
        taken  = 1'b0;
        kind   = kindAlu;
        wbReg  = (iw.iFields.opcode == 6'b000000) ? iw.rFields.rd : iw.iFields.rt;
        case (iw.iFields.opcode)
            6'b000000: begin
                case (iw.rFields.funct)
                    6'h20, 6'h21: result = a + b;
                    6'h22, 6'h23: result = a - b;
                    6'h24: result = a & b;
                    6'h25: result = a | b;
                    6'h26: result = a ^ b;
                    6'h27: result = ~(a | b);
                    6'h2A: result = {31'd0, $signed(a) < $signed(b)};
                    6'h2B: result = {31'd0, a < b};
                    6'h00: result = b << iw.rFields.shamt;
                    6'h02: result = b >> iw.rFields.shamt;
                    6'h03: result = $signed(b) >>> iw.rFields.shamt;
                    6'h04: result = b << a[4:0];
                    6'h06: result = b >> a[4:0];
                    6'h07: result = $signed(b) >>> a[4:0];
                    6'h08: begin
                        kind   = kindJr;
                        target = a;
                    end
                    default: kind = kindIllegal;
                endcase
            end
            6'h08, 6'h09: result = a + seImm;
            6'h0A: result = {31'd0, $signed(a) < $signed(seImm)};
            6'h0B: result = {31'd0, a < seImm};
            6'h0C: result = a & zeImm;
            6'h0D: result = a | zeImm;
            6'h0E: result = a ^ zeImm;
            6'h0F: result = {iw.iFields.imm, 16'h0000};
            6'h04, 6'h05: begin
                kind   = kindBranch;
                target = pc + (seImm << 2);
                taken  = (a == b) ^ iw.iFields.opcode[0];  // bne has the opposite sense
            end
            default: kind = kindIllegal;
        endcase
        wbEn   = (kind == kindAlu);
        status = {taken, 1'b0, kind == kindJr, (kind == kindBranch) ? a == b : result == 0};
        if (kind == kindIllegal) status = 4'b0100;
    endtask

    task automatic runInstr(input instrWord iw);
        logic [31:0] value;
        logic [31:0] pc;
        logic [31:0] rdata;
        logic [31:0] result;
        logic [31:0] target;
        logic [31:0] mask;
        logic [3:0]  status;
        logic [4:0]  wbReg;
        logic        wbEn;
        logic        err;
        int          kind;
        int          waits;
        value = nextRandom();
        writeReg(iw.rFields.rs, value);
        if (randBelow(4) != 0) value = nextRandom();  // else equal operands for beq and sub
        writeReg(iw.rFields.rt, value);
        pc = nextRandom() & 32'hFFFF_FFFC;
        busOp(1'b1, `EXEC_PC, pc, 1'b0, rdata);
        modelExec(iw, pc, result, target, status, wbEn, wbReg, kind);
        apbTransfer(1'b1, `EXEC_INSTR, iw, rdata, err, waits);
        checkEq("pslverr", {31'd0, kind == kindIllegal}, {31'd0, err});
        checkWaits(`EXEC_INSTR, 1, waits);
        busOp(1'b0, `EXEC_INSTR, '0, 1'b0, rdata);
        checkEq("INSTR", iw, rdata);
        if (wbEn && wbReg != 5'd0) shadow[wbReg] = result;
        if (kind == kindAlu) begin
            resultExp   = result;
            resultKnown = 1'b1;
            addrKnown   = 1'b0;
        end else if (kind != kindIllegal) begin
            addrExp     = target;
            addrKnown   = 1'b1;
            resultKnown = 1'b0;
        end
        checkOutputRegs();
        busOp(1'b0, `EXEC_STATUS, '0, 1'b0, rdata);
        mask = (kind == kindJr) ? 32'hE : 32'hF;  // zero flag undefined for jr
        checkEq("STATUS", {28'd0, status} & mask, rdata & mask);
        readReg(wbEn ? wbReg : iw.rFields.rd);
        readReg(5'(randBelow(32)));
    endtask

    initial begin
        logic [31:0] rdata;
        rst         <= 1'b1;
        apbIn       <= '0;
        lcgState    = 32'h5b05_95c1;
        errorCount  = 0;
        checkCount  = 0;
        resultKnown = 1'b0;
        addrKnown   = 1'b0;
        for (int n = 0; n < `MIPS_NREGS; n++) begin
            shadow[n] = '0;
        end
        repeat (16) @(posedge clock);
        rst <= 1'b0;
        sweepRegs();
        busOp(1'b0, `EXEC_PC, '0, 1'b0, rdata);
        checkEq("PC", '0, rdata);
        for (int n = 0; n < `MIPS_NREGS; n++) begin
            writeReg(5'(n), nextRandom());
        end
        sweepRegs();
        busOp(1'b1, 12'h094, nextRandom(), 1'b1, rdata);   // just past the map
        busOp(1'b0, 12'h400, '0, 1'b1, rdata);
        busOp(1'b1, 12'h006, nextRandom(), 1'b1, rdata);   // unaligned window word
        busOp(1'b1, `EXEC_STATUS, 32'hF, 1'b1, rdata);
        busOp(1'b0, `EXEC_STATUS, '0, 1'b0, rdata);
        checkEq("STATUS", '0, rdata);
        sweepRegs();
        repeat (numInstr) runInstr(randomInstr());
        busOp(1'b1, `EXEC_RESULT, nextRandom(), 1'b1, rdata);
        busOp(1'b1, `EXEC_ADDR, nextRandom(), 1'b1, rdata);
        checkOutputRegs();
        sweepRegs();
        errorCount += u_execTop.u_execProperties.failCount;
        $display("errors: %0d of %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: verif/exec_properties.sv
`timescale 1ns/1ps
`include "mips_config.svh"

module execProperties (
    input logic           clock,
    input logic           rst,
    input mipsPkg::apbReq apbIn,
    input mipsPkg::apbRsp apbOut
);

    logic access;
    logic instrWrite;
    int   failCount = 0;  // read by the testbench at the end of the run

    assign access     = apbIn.psel & apbIn.penable;
    assign instrWrite = access & apbIn.pwrite & (apbIn.paddr == `EXEC_INSTR);

    // the only stall is the first access cycle of an instruction write
    readyLowOnlyInWait: assert property (@(posedge clock) disable iff (rst)
        !apbOut.pready |-> instrWrite && !$past(apbIn.penable)
    ) else begin
        failCount++;
        $error("pready low outside the instruction wait state");
    end

    errorOnlyWhenReady: assert property (@(posedge clock) disable iff (rst)
        !apbOut.pready |-> !apbOut.pslverr
    ) else begin
        failCount++;
        $error("pslverr raised while pready is low");
    end

    windowZeroReadsZero: assert property (@(posedge clock) disable iff (rst)
        access && apbOut.pready && !apbIn.pwrite && apbIn.paddr == `EXEC_REG_BASE
            |-> apbOut.prdata == 32'd0
    ) else begin
        failCount++;
        $error("read of register 0 returned a nonzero value");
    end

    readyAfterReset: assert property (@(posedge clock)
        $fell(rst) |-> apbOut.pready
    ) else begin
        failCount++;
        $error("pready low in the first cycle after reset");
    end

endmodule

bind execTop execProperties u_execProperties (
    .clock(clock), .rst(rst), .apbIn(apbIn), .apbOut(apbOut)
);
